/* ksCons_macros.svh */
// Console subsystem constants (ROM width, clock-enable ratio, microcode entry points); include where needed
`ifndef KS_CONS_MACROS_SVH
`define KS_CONS_MACROS_SVH

////////////////////
// Control ROM geometry
////////////////////

// Address width of the control ROM
// Sixteen words are enough for the console microprogram
`define CROM_AW 4

////////////////////
// Clock enable
////////////////////

// Number of clk cycles per clken pulse
`define CLKEN_DIV 4

////////////////////
// Microprogram entry points
////////////////////

// Idle loop, dispatches on the console flags
`define UADDR_IDLE 0

// Halt entry, sets HALT and returns to idle
`define UADDR_HALT 2

// Single instruction execute entry
`define UADDR_EXEC 4

// Run entry, clears HALT and then loops
`define UADDR_RUN 8

`endif

/* ksConsPkg.sv */
// Shared console types (microword, host command, status flags); import where the types are used
`default_nettype none

`include "ksCons_macros.svh"

package ksConsPkg;

   ////////////////////
   // Microword fields
   ////////////////////

   // Special function select
   // Only the console select matters here
   typedef enum logic [2:0] {
      SPEC_NOP  = 3'd0,
      SPEC_CONS = 3'd5
   } specSelT;

   // Next address source
   typedef enum logic [1:0] {
      BR_NEXT = 2'd0,
      BR_JUMP = 2'd1,
      BR_DISP = 2'd2,
      BR_LOOP = 2'd3
   } brTypeT;

   // Reduced microword
   // Console flag controls plus branch control
   typedef struct packed {
      logic                 specEn;
      specSelT              specSel;
      logic                 setHalt;
      logic                 clrHalt;
      logic                 clrRun;
      logic                 clrExec;
      logic                 clrCont;
      brTypeT               brType;
      logic [`CROM_AW-1:0]  jumpAddr;
   } cromWordT;

   ////////////////////
   // Console channel
   ////////////////////

   // Host command, write selects switch update vs plain read
   typedef struct packed {
      logic write;
      logic run;
      logic cont;
      logic exec;
   } consCmdT;

   // Processor status flags
   typedef struct packed {
      logic run;
      logic cont;
      logic exec;
      logic halt;
   } consStatT;

endpackage

`default_nettype wire

/* ksConsIntf.sv */
// Console status flags (RUN, CONT, EXEC, HALT) driven by microcode and console writes; one per CPU
`default_nettype none
`timescale 1ns/1ps

module ksConsIntf
   import ksConsPkg::*;
(
   input  wire           clk,
   input  wire           rst,
   input  wire           clken,
   input  wire cromWordT crom,
   input  wire           debugHalt,
   input  wire           cslSet,
   input  wire consCmdT  cslCmd,
   output consStatT      stat
);

   // Console special function decode
   logic specCons;

   // Flag registers
   logic runQ;
   logic contQ;
   logic execQ;
   logic haltQ;

   assign specCons = crom.specEn & (crom.specSel == SPEC_CONS);

   ////////////////////
   // HALT
   ////////////////////

   // Set has priority over clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         haltQ <= 1'b0;
      else if (clken)
      begin
         if (specCons & crom.setHalt)
            haltQ <= 1'b1;
         else if (specCons & crom.clrHalt)
            haltQ <= 1'b0;
      end
   end

   ////////////////////
   // RUN
   ////////////////////

   // Breakpoint or microcode clear wins over the switch
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         runQ <= 1'b0;
      else if (clken)
      begin
         if ((specCons & crom.clrRun) | debugHalt)
            runQ <= 1'b0;
         else if (cslSet)
            runQ <= cslCmd.run;
      end
   end

   ////////////////////
   // EXEC and CONT
   ////////////////////

   // Microcode clear wins over the switch
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         execQ <= 1'b0;
         contQ <= 1'b0;
      end
      else if (clken)
      begin
         if (specCons & crom.clrExec)
            execQ <= 1'b0;
         else if (cslSet)
            execQ <= cslCmd.exec;
         // Same pattern for continue
         if (specCons & crom.clrCont)
            contQ <= 1'b0;
         else if (cslSet)
            contQ <= cslCmd.cont;
      end
   end

   assign stat = '{run: runQ, cont: contQ, exec: execQ, halt: haltQ};

endmodule

`default_nettype wire

/* ksMicroSeq.sv */
// Console microsequencer with clock-enable divider, program counter and control ROM
`default_nettype none
`timescale 1ns/1ps

`include "ksCons_macros.svh"

module ksMicroSeq
   import ksConsPkg::*;
(
   input  wire           clk,
   input  wire           rst,
   input  wire consStatT stat,
   output logic          clken,
   output cromWordT      crom
);

   localparam int DivW = $clog2(`CLKEN_DIV);

   // ROM addresses
   localparam logic [`CROM_AW-1:0] IdleAddr = `CROM_AW'(`UADDR_IDLE);
   localparam logic [`CROM_AW-1:0] HaltAddr = `CROM_AW'(`UADDR_HALT);
   localparam logic [`CROM_AW-1:0] ExecAddr = `CROM_AW'(`UADDR_EXEC);
   localparam logic [`CROM_AW-1:0] RunAddr  = `CROM_AW'(`UADDR_RUN);
   localparam logic [`CROM_AW-1:0] LoopAddr = `CROM_AW'(`UADDR_RUN + 1);
   localparam logic [`CROM_AW-1:0] LastAddr = '1;

   logic [DivW-1:0]     divCnt;
   logic [`CROM_AW-1:0] upc;
   logic [`CROM_AW-1:0] nextAddr;

   // Build one microword
   function automatic cromWordT mkWord(input logic cons, input logic setH,
                                       input logic clrH, input logic clrE,
                                       input logic clrC, input brTypeT br,
                                       input logic [`CROM_AW-1:0] ja);
      return '{specEn: cons, specSel: (cons ? SPEC_CONS : SPEC_NOP),
               setHalt: setH, clrHalt: clrH, clrRun: 1'b0, clrExec: clrE,
               clrCont: clrC, brType: br, jumpAddr: ja};
   endfunction

   ////////////////////
   // Clock enable
   ////////////////////

   // Registered pulse, one clk wide every CLKEN_DIV cycles
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         divCnt <= '0;
         clken  <= 1'b0;
      end
      else
      begin
         divCnt <= (divCnt == DivW'(`CLKEN_DIV - 1)) ? '0 : divCnt + 1'b1;
         clken  <= (divCnt == DivW'(`CLKEN_DIV - 2));
      end
   end

   ////////////////////
   // Next address
   ////////////////////

   always_comb
   begin
      unique case (crom.brType)
         BR_NEXT: nextAddr = upc + 1'b1;
         BR_JUMP: nextAddr = crom.jumpAddr;
         // Idle dispatch on console flags, jumpAddr is the fall-through
         BR_DISP:
         begin
            if (stat.exec)
               nextAddr = ExecAddr;
            else if ((stat.cont & stat.halt) | (stat.run & ~stat.halt))
               nextAddr = RunAddr;
            else
               nextAddr = crom.jumpAddr;
         end
         // Keep looping while RUN holds
         default: nextAddr = stat.run ? crom.jumpAddr : HaltAddr;
      endcase
   end

   // Microprogram counter, steps only on clken
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         upc <= IdleAddr;
      else if (clken)
         upc <= nextAddr;
   end

   ////////////////////
   // Control ROM
   ////////////////////

   always_comb
   begin
      case (upc) inside
         IdleAddr: crom = mkWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, BR_DISP, IdleAddr);
         // Halt entry, CONT drops here too
         HaltAddr: crom = mkWord(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, BR_JUMP, IdleAddr);
         ExecAddr: crom = mkWord(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, BR_JUMP, HaltAddr);
         // Run entry also consumes a continue request
         RunAddr:  crom = mkWord(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, BR_NEXT, IdleAddr);
         [LoopAddr:LastAddr - 1'b1]:
            crom = mkWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, BR_NEXT, IdleAddr);
         LastAddr: crom = mkWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, BR_LOOP, LoopAddr);
         // Unused words fall back to idle
         default:  crom = mkWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, BR_JUMP, IdleAddr);
      endcase
   end

endmodule

`default_nettype wire

/* ksConsoleCtrl.sv */
// Console host controller: four-phase req/ack, switch write strobe and status snapshot
`default_nettype none
`timescale 1ns/1ps

module ksConsoleCtrl
   import ksConsPkg::*;
(
   input  wire           clk,
   input  wire           rst,
   input  wire           clken,
   input  wire           hostReq,
   input  wire consCmdT  hostCmd,
   input  wire consStatT stat,
   output logic          hostAck,
   output consStatT      hostStat,
   output logic          cslSet,
   output consCmdT       cslCmd
);

   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_APPLY   = 2'd1,
      ST_RESPOND = 2'd2,
      ST_RELEASE = 2'd3
   } ctrlStateT;

   ctrlStateT state;
   consCmdT   cmdQ;
   consStatT  statQ;

   ////////////////////
   // Handshake FSM
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         state <= ST_IDLE;
      else
      begin
         case (state)
            // New request only once ack is low
            ST_IDLE:    if (hostReq) state <= ST_APPLY;
            // Switch write lands on this clken
            ST_APPLY:   if (clken) state <= ST_RESPOND;
            // Snapshot on the following clken
            ST_RESPOND: if (clken) state <= ST_RELEASE;
            // Ack drops one cycle after req drops
            default:    if (!hostReq) state <= ST_IDLE;
         endcase
      end
   end

   // Command and snapshot registers
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && hostReq)
         cmdQ <= hostCmd;
      if (state == ST_RESPOND && clken)
         statQ <= stat;
   end

   // Strobe coincides with clken, writes only
   assign cslSet   = (state == ST_APPLY) & clken & cmdQ.write;
   assign cslCmd   = cmdQ;
   assign hostAck  = (state == ST_RELEASE);
   assign hostStat = statQ;

endmodule

`default_nettype wire

/* ksConsTop.sv */
// Console subsystem top: host controller, microsequencer and status flags
`default_nettype none
`timescale 1ns/1ps

module ksConsTop
   import ksConsPkg::*;
(
   input  wire           clk,
   input  wire           rst,
   input  wire           hostReq,
   input  wire consCmdT  hostCmd,
   input  wire           debugHalt,
   output wire           hostAck,
   output wire consStatT hostStat,
   output wire consStatT cpuStat
);

   // Sequencer outputs
   wire           clken;
   wire cromWordT crom;

   // Console switch path
   wire           cslSet;
   wire consCmdT  cslCmd;

   ksConsoleCtrl u_ksConsoleCtrl (
      .clk      (clk),
      .rst      (rst),
      .clken    (clken),
      .hostReq  (hostReq),
      .hostCmd  (hostCmd),
      .stat     (cpuStat),
      .hostAck  (hostAck),
      .hostStat (hostStat),
      .cslSet   (cslSet),
      .cslCmd   (cslCmd)
   );

   // Branches on the same flags the host sees
   ksMicroSeq u_ksMicroSeq (
      .clk   (clk),
      .rst   (rst),
      .stat  (cpuStat),
      .clken (clken),
      .crom  (crom)
   );

   ksConsIntf u_ksConsIntf (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .crom      (crom),
      .debugHalt (debugHalt),
      .cslSet    (cslSet),
      .cslCmd    (cslCmd),
      .stat      (cpuStat)
   );

endmodule

`default_nettype wire

/* tbKsCons.sv */
// Self-checking testbench for the console subsystem; compile with all.f, top module tbKsCons
`default_nettype none
`timescale 1ns/1ps

`include "ksCons_macros.svh"

module tbKsCons
   import ksConsPkg::*;
();

   // Run limit covers six tests of up to about 300 cycles plus margin
   localparam int MaxCycles = 4000;
   // Forty clken periods
   localparam int HaltWaitCycles = 40 * `CLKEN_DIV;

   logic     clk;
   logic     rst;
   logic     hostReq;
   consCmdT  hostCmd;
   logic     debugHalt;
   logic     hostAck;
   consStatT hostStat;
   consStatT cpuStat;

   int       seed;
   int       cycleCount;
   int       errCount;
   int       testErrStart;
   int       passCount;
   int       failCount;
   logic     ackPrev;
   logic     reqPrev;
   consStatT got;

   ksConsTop u_ksConsTop (
      .clk       (clk),
      .rst       (rst),
      .hostReq   (hostReq),
      .hostCmd   (hostCmd),
      .debugHalt (debugHalt),
      .hostAck   (hostAck),
      .hostStat  (hostStat),
      .cpuStat   (cpuStat)
   );

   ////////////////////
   // Clock and watchdog
   ////////////////////

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= MaxCycles)
      begin
         $display("Timeout: run reached %0d cycles without finishing", MaxCycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   ////////////////////
   // Handshake monitor
   ////////////////////

   // Ack may only rise under req and only fall after req is gone
   always @(negedge clk)
   begin
      if (!rst && hostAck && !ackPrev)
      begin
         assert (hostReq)
         else
         begin
            $display("Handshake error: hostAck rose while hostReq was low");
            errCount = errCount + 1;
         end
      end
      if (!rst && !hostAck && ackPrev)
      begin
         assert (!reqPrev)
         else
         begin
            $display("Handshake error: hostAck fell while hostReq was still high");
            errCount = errCount + 1;
         end
      end
      ackPrev <= hostAck;
      reqPrev <= hostReq;
   end

   ////////////////////
   // Helpers
   ////////////////////

   function automatic consStatT mkStat(input logic run, input logic cont,
                                       input logic exec, input logic halt);
      return '{run: run, cont: cont, exec: exec, halt: halt};
   endfunction

   function automatic consCmdT mkCmd(input logic write, input logic run,
                                     input logic cont, input logic exec);
      return '{write: write, run: run, cont: cont, exec: exec};
   endfunction

   task automatic applyReset();
      @(posedge clk);
      rst <= 1'b1;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
   endtask

   // Random spacing between requests
   task automatic idleGap();
      int gap;
      gap = $unsigned($random(seed)) % 6;
      repeat (gap) @(posedge clk);
   endtask

   // One full four-phase transfer
   task automatic hostXfer(input consCmdT cmd, output consStatT stat);
      @(negedge clk);
      while (hostAck)
         @(negedge clk);
      @(posedge clk);
      hostCmd <= cmd;
      hostReq <= 1'b1;
      @(negedge clk);
      while (!hostAck)
         @(negedge clk);
      // Status is valid together with ack
      stat = hostStat;
      @(posedge clk);
      hostReq <= 1'b0;
      @(negedge clk);
      while (hostAck)
         @(negedge clk);
   endtask

   task automatic checkStat(input string name, input consStatT actual, input consStatT exp);
      assert (actual == exp)
      else
      begin
         $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, actual);
         errCount = errCount + 1;
      end
   endtask

   task automatic waitForHalt();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!cpuStat.halt && cycles < HaltWaitCycles)
      begin
         @(negedge clk);
         cycles = cycles + 1;
      end
      assert (cpuStat.halt)
      else
      begin
         $display("HALT was not set within 40 clken periods");
         errCount = errCount + 1;
      end
   endtask

   task automatic reportTest(input string name);
      if (errCount == testErrStart)
      begin
         passCount = passCount + 1;
         $display("PASS  %s", name);
      end
      else
      begin
         failCount = failCount + 1;
         $display("FAIL  %s (%0d errors)", name, errCount - testErrStart);
      end
      testErrStart = errCount;
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      seed         = 32'h15b423c7;
      cycleCount   = 0;
      errCount     = 0;
      testErrStart = 0;
      passCount    = 0;
      failCount    = 0;
      ackPrev      = 1'b0;
      reqPrev      = 1'b0;
      rst          = 1'b1;
      hostReq      = 1'b0;
      hostCmd      = '0;
      debugHalt    = 1'b0;
      applyReset();

      // Everything quiet after reset
      @(negedge clk);
      checkStat("cpuStat", cpuStat, mkStat(0, 0, 0, 0));
      assert (!hostAck)
      else
      begin
         $display("Mismatch hostAck: expected 0x0, got 0x%h", hostAck);
         errCount = errCount + 1;
      end
      hostXfer(mkCmd(0, 0, 0, 0), got);
      checkStat("hostStat", got, mkStat(0, 0, 0, 0));
      reportTest("Test 1 reset state and read");

      // Single step through EXEC into HALT
      idleGap();
      hostXfer(mkCmd(1, 0, 0, 1), got);
      checkStat("hostStat", got, mkStat(0, 0, 1, 0));
      waitForHalt();
      checkStat("cpuStat", cpuStat, mkStat(0, 0, 0, 1));
      idleGap();
      hostXfer(mkCmd(0, 0, 0, 0), got);
      checkStat("hostStat", got, mkStat(0, 0, 0, 1));
      reportTest("Test 2 exec step ends in halt");

      // Fresh start so RUN alone can enter the loop
      applyReset();
      hostXfer(mkCmd(1, 1, 0, 0), got);
      checkStat("hostStat", got, mkStat(1, 0, 0, 0));
      idleGap();
      hostXfer(mkCmd(0, 0, 0, 0), got);
      checkStat("hostStat", got, mkStat(1, 0, 0, 0));
      reportTest("Test 3 run switch and handshake order");

      // Breakpoint drops RUN and the loop exits to halt
      @(posedge clk);
      debugHalt <= 1'b1;
      waitForHalt();
      checkStat("cpuStat", cpuStat, mkStat(0, 0, 0, 1));
      @(posedge clk);
      debugHalt <= 1'b0;
      idleGap();
      hostXfer(mkCmd(0, 0, 0, 0), got);
      checkStat("hostStat", got, mkStat(0, 0, 0, 1));
      reportTest("Test 4 breakpoint halt");

      // Continue from halt
      idleGap();
      hostXfer(mkCmd(1, 1, 1, 0), got);
      checkStat("hostStat", got, mkStat(1, 1, 0, 1));
      idleGap();
      hostXfer(mkCmd(0, 0, 0, 0), got);
      checkStat("hostStat", got, mkStat(1, 0, 0, 0));
      reportTest("Test 5 continue resumes run");

      // Switch RUN off so the loop exits at word 15
      idleGap();
      hostXfer(mkCmd(1, 0, 0, 0), got);
      checkStat("hostStat", got, mkStat(0, 0, 0, 0));
      waitForHalt();
      checkStat("cpuStat", cpuStat, mkStat(0, 0, 0, 1));
      idleGap();
      hostXfer(mkCmd(0, 0, 0, 0), got);
      checkStat("hostStat", got, mkStat(0, 0, 0, 1));
      reportTest("Test 6 run off stops at halt");

      $display("Tests passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
ksConsPkg.sv
ksConsIntf.sv
ksMicroSeq.sv
ksConsoleCtrl.sv
ksConsTop.sv
tbKsCons.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the console subsystem simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f all.f --top-module tbKsCons -o simKsCons \
   > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/simKsCons > sim.log 2>&1 ; cat sim.log

grep -q "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }
